// File: design/neuro_config.svh
/*
 * Neuron network configuration
 * Fixed-point constants for the 2.16 chattering-burster network, step
 * divider, synapse and bias values
 */
`ifndef NEURO_CONFIG_SVH
`define NEURO_CONFIG_SVH

// Clocks per network time step (board divider was 4096)
`define NEURO_STEP_DIV		16

// Izhikevich state constants, table values scaled by 0.01
`define NEURO_V_RESET		18'sh34CCD	// -0.7
`define NEURO_U_RESET		18'sh3CCCD	// -0.2
`define NEURO_V_PEAK		18'sh04CCC	// 0.30 spike threshold
`define NEURO_C14			18'sh16666	// 1.4

// Chattering burster, a and b as right shifts
`define NEURO_A_SHIFT		4'd6		// About 0.016
`define NEURO_B_SHIFT		4'd2		// 0.25
`define NEURO_C_RESET		18'sh38000	// -0.5 after a spike
`define NEURO_D_JUMP		18'sh0051E	// 0.02 recovery kick

// Mutual inhibition inside a pair
`define NEURO_SYN_WEIGHT	18'sh3F000	// Small negative weight
`define NEURO_SYN_TAU		4'd4		// Decay shift, about 1 ms

// Bias currents and electrical coupling
`define NEURO_I_BASE		18'sh00D00
`define NEURO_I_DELTA		16			// Offset between cells
`define NEURO_GJ_COND		4'd6		// Conductance shift

`endif

// File: design/neuro_pkg.sv
/*
 * Neuron network package
 * Fixed-point vector types and the gap-junction mode
 */
package neuro_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int FIX_W    = 18;	// 2.16 signed
	localparam int SAMPLE_W = 16;	// Top bits of a voltage
	localparam int SHIFT_W  = 4;

	// Voltages, recovery, currents and weights
	typedef logic signed [FIX_W-1:0] fix_t;

	// Output voltage sample
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Shift-coded a, b, tau and conductance
	typedef logic [SHIFT_W-1:0] shift_t;

	// Junction rectification
	typedef enum logic
	{
		GJ_NONE,	// Current both ways
		GJ_FORWARD	// Only when the first cell is higher
	} gj_mode_t;

endpackage

// File: design/gap_junction_if.sv
/*
 * Gap-junction link between the two neuron pairs
 * Voltage taps and daisy-chained currents, purely combinational
 */
`timescale 1ns/10ps

interface gap_junction_if;
	import neuro_pkg::*;

	fix_t v_pre;		// Voltage of the first cell
	fix_t v_post;		// Voltage of the second cell
	fix_t i_pre_in;		// Current arriving for the first cell
	fix_t i_post_in;	// Current arriving for the second cell
	fix_t i_pre_out;	// Total current into the first cell
	fix_t i_post_out;	// Total current into the second cell

	// Pair holding the first cell
	modport pre_side (output v_pre, i_pre_in, input i_pre_out);

	// Pair holding the second cell
	modport post_side (output v_post, i_post_in, input i_post_out);

	// The coupling itself
	modport junction (
		input  v_pre, v_post, i_pre_in, i_post_in,
		output i_pre_out, i_post_out
	);

endinterface

// File: design/izh_neuron.sv
/*
 * Izhikevich neuron, 2.16 fixed point
 * Euler update once per step enable, threshold and reset jump,
 * a and b applied as right shifts so only v squared needs a multiply
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module izh_neuron
#(
	parameter neuro_pkg::shift_t A_SHIFT = `NEURO_A_SHIFT,
	parameter neuro_pkg::shift_t B_SHIFT = `NEURO_B_SHIFT,
	parameter neuro_pkg::fix_t   C_RESET = `NEURO_C_RESET,
	parameter neuro_pkg::fix_t   D_JUMP  = `NEURO_D_JUMP
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic             step,		// One network time step
	input  neuro_pkg::fix_t  i_in,		// Total input current
	output neuro_pkg::fix_t  v,			// Membrane voltage
	output logic             spike		// Set for the step after a peak
);
	import neuro_pkg::*;

	localparam fix_t V_PEAK  = `NEURO_V_PEAK;
	localparam fix_t V_RESET = `NEURO_V_RESET;
	localparam fix_t U_RESET = `NEURO_U_RESET;
	localparam fix_t C14     = `NEURO_C14;

	fix_t u;						// Recovery variable
	logic signed [35:0] v_prod;		// Full v*v product
	fix_t v_sq;
	fix_t dv_sum;
	fix_t v_next;
	fix_t v_xb;
	fix_t u_diff;
	fix_t du;
	fix_t u_next;
	fix_t u_jump;

	//////////////////////////////////////////////////
	// Voltage, dt = 1/16 folded into the shifts
	//////////////////////////////////////////////////
	assign v_prod = v * v;
	assign v_sq   = {v_prod[35], v_prod[32:16]};	// Back to 2.16, sign kept

	// (v^2 + 5/4 v + 1.4/4 - u/4 + I/4) / 4
	assign dv_sum = v_sq + v + (v >>> 2) + (C14 >>> 2) - (u >>> 2) + (i_in >>> 2);
	assign v_next = v + (dv_sum >>> 2);

	//////////////////////////////////////////////////
	// Recovery, dt*a*(b*v - u)
	//////////////////////////////////////////////////
	assign v_xb   = v >>> B_SHIFT;		// b*v
	assign u_diff = v_xb - u;
	assign du     = u_diff >>> A_SHIFT;	// times a
	assign u_next = u + (du >>> 4);		// times dt
	assign u_jump = u + D_JUMP;			// After a spike

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			v     <= V_RESET;
			u     <= U_RESET;
			spike <= 1'b0;
		end
		else if (step)
		begin
			if (v > V_PEAK)	// Peak reached, jump back
			begin
				v     <= C_RESET;
				u     <= u_jump;
				spike <= 1'b1;
			end
			else
			begin
				v     <= v_next;
				u     <= u_next;
				spike <= 1'b0;
			end
		end
	end

endmodule

// File: design/neuron_pair.sv
/*
 * Neuron pair with mutual inhibition
 * Two bursters cross-coupled by decaying inhibitory synapses, neuron A
 * takes its input through the gap junction, neuron B directly
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module neuron_pair
#(
	parameter neuro_pkg::fix_t BIAS_A  = `NEURO_I_BASE,
	parameter neuro_pkg::fix_t BIAS_B  = `NEURO_I_BASE,
	parameter bit              TAP_PRE = 1'b1	// 1 taps the pre side
)
(
	input  logic            clk,
	input  logic            reset,
	input  logic            step,
	gap_junction_if         gap,		// Side chosen by the parent
	output neuro_pkg::fix_t v_a,
	output neuro_pkg::fix_t v_b,
	output logic [1:0]      spikes		// {B, A}
);
	import neuro_pkg::*;

	localparam fix_t   SYN_W   = `NEURO_SYN_WEIGHT;
	localparam shift_t SYN_TAU = `NEURO_SYN_TAU;

	fix_t syn_a;		// Inhibition onto A, driven by B
	fix_t syn_b;		// Inhibition onto B, driven by A
	fix_t i_syn_a;		// A's synapse plus bias, to the junction
	fix_t i_in_a;		// Back from the junction
	fix_t i_in_b;
	logic spike_a;
	logic spike_b;

	//////////////////////////////////////////////////
	// Synapse state
	//////////////////////////////////////////////////
	// Exponential decay, partner spike adds the weight
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			syn_a <= '0;
			syn_b <= '0;
		end
		else if (step)
		begin
			syn_a <= syn_a - (syn_a >>> SYN_TAU) + (spike_b ? SYN_W : fix_t'(0));
			syn_b <= syn_b - (syn_b >>> SYN_TAU) + (spike_a ? SYN_W : fix_t'(0));
		end
	end

	assign i_syn_a = syn_a + BIAS_A;
	assign i_in_b  = syn_b + BIAS_B;

	// Junction tap
	generate
		if (TAP_PRE)
		begin : g_pre
			assign gap.v_pre    = v_a;
			assign gap.i_pre_in = i_syn_a;
			assign i_in_a       = gap.i_pre_out;
		end
		else
		begin : g_post
			assign gap.v_post    = v_a;
			assign gap.i_post_in = i_syn_a;
			assign i_in_a        = gap.i_post_out;
		end
	endgenerate

	izh_neuron neuron_a (.clk(clk), .reset(reset), .step(step), .i_in(i_in_a),
		.v(v_a), .spike(spike_a));

	izh_neuron neuron_b (.clk(clk), .reset(reset), .step(step), .i_in(i_in_b),
		.v(v_b), .spike(spike_b));

	assign spikes = {spike_b, spike_a};

endmodule

// File: design/gap_junction.sv
/*
 * Electrical synapse
 * Resistive coupling between two cells, conductance as a right shift,
 * optionally rectified so current only flows from the first cell
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module gap_junction
#(
	parameter neuro_pkg::shift_t   COND = `NEURO_GJ_COND,
	parameter neuro_pkg::gj_mode_t MODE = neuro_pkg::GJ_FORWARD
)
(
	gap_junction_if.junction gap
);
	import neuro_pkg::*;

	fix_t diff;			// v_pre - v_post
	fix_t diff_rect;	// After rectification
	fix_t diff_neg;

	assign diff = gap.v_pre - gap.v_post;

	// Forward mode blocks current back into the first cell
	always_comb
	begin
		if (MODE == GJ_NONE || diff > 0)
			diff_rect = diff;
		else
			diff_rect = '0;
	end

	assign diff_neg = -diff_rect;

	//////////////////////////////////////////////////
	// Equal and opposite currents
	//////////////////////////////////////////////////
	assign gap.i_post_out = gap.i_post_in + (diff_rect >>> COND);	// Into the lower cell
	assign gap.i_pre_out  = gap.i_pre_in + (diff_neg >>> COND);	// Drawn from the higher

endmodule

// File: design/step_sequencer.sv
/*
 * Network step sequencer
 * Divides clk into time steps, captures one output sample per step and
 * holds the network while the sample waits for the consumer
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module step_sequencer
(
	input  logic                clk,
	input  logic                reset,
	input  neuro_pkg::fix_t     v_n1,
	input  neuro_pkg::fix_t     v_n2,
	input  neuro_pkg::fix_t     v_n3,
	input  neuro_pkg::fix_t     v_n4,
	input  logic [3:0]          spikes,			// Neuron 4 down to 1
	input  logic                sel_left,		// 1 picks neuron 1, else 2
	input  logic                sel_right,		// 1 picks neuron 3, else 4
	input  logic                sample_ready,
	output logic                step,			// Network advances at this edge
	output logic                sample_valid,
	output neuro_pkg::sample_t  sample_left,
	output neuro_pkg::sample_t  sample_right,
	output logic [3:0]          sample_spikes
);
	import neuro_pkg::*;

	// Divider needs at least two clocks per step
	localparam int              CNT_W    = $clog2(`NEURO_STEP_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`NEURO_STEP_DIV - 1);

	logic [CNT_W-1:0] count;
	logic             capture;		// Network just stepped

	// Last counted cycle, never while a sample is pending
	assign step = !sample_valid && !capture && (count == CNT_LAST);

	//////////////////////////////////////////////////
	// Divider and handshake
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count        <= '0;
			capture      <= 1'b0;
			sample_valid <= 1'b0;
		end
		else
		begin
			capture <= step;
			if (sample_valid)
			begin
				if (sample_ready)		// Accepted, restart the divider
				begin
					sample_valid <= 1'b0;
					count        <= '0;
				end
			end
			else if (capture)
				sample_valid <= 1'b1;	// New data now in the register
			else if (step)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// Sample register, selects taken on the capture edge
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			sample_left   <= sel_left ? v_n1[17:2] : v_n2[17:2];
			sample_right  <= sel_right ? v_n3[17:2] : v_n4[17:2];
			sample_spikes <= spikes;
		end
	end

endmodule

// File: design/neuro_top.sv
/*
 * Four-neuron spiking network
 * Two mutually inhibiting burster pairs, neuron 1 drives neuron 3 through
 * a forward gap junction, one sample per step out over valid/ready
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module neuro_top
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sel_left,		// Neuron 1 or 2
	input  logic                sel_right,		// Neuron 3 or 4
	input  logic                sample_ready,
	output logic                sample_valid,
	output neuro_pkg::sample_t  sample_left,
	output neuro_pkg::sample_t  sample_right,
	output logic [3:0]          sample_spikes	// Neuron 4 down to 1
);
	import neuro_pkg::*;

	fix_t       v_n1;
	fix_t       v_n2;
	fix_t       v_n3;
	fix_t       v_n4;
	logic [1:0] spikes_a;		// Neurons 2 and 1
	logic [1:0] spikes_b;		// Neurons 4 and 3
	logic       step;

	gap_junction_if gj ();

	//////////////////////////////////////////////////
	// Network
	//////////////////////////////////////////////////
	// Neuron 1 at base bias, neuron 2 slightly above
	neuron_pair #(
		.BIAS_A  (fix_t'(`NEURO_I_BASE)),
		.BIAS_B  (fix_t'(`NEURO_I_BASE + `NEURO_I_DELTA)),
		.TAP_PRE (1'b1)
	) pair_a (
		.clk(clk), .reset(reset), .step(step), .gap(gj.pre_side),
		.v_a(v_n1), .v_b(v_n2), .spikes(spikes_a)
	);

	// Neurons 3 and 4 slightly below base
	neuron_pair #(
		.BIAS_A  (fix_t'(`NEURO_I_BASE - `NEURO_I_DELTA)),
		.BIAS_B  (fix_t'(`NEURO_I_BASE - `NEURO_I_DELTA)),
		.TAP_PRE (1'b0)
	) pair_b (
		.clk(clk), .reset(reset), .step(step), .gap(gj.post_side),
		.v_a(v_n3), .v_b(v_n4), .spikes(spikes_b)
	);

	// Neuron 1 to neuron 3 only
	gap_junction #(.COND(`NEURO_GJ_COND), .MODE(GJ_FORWARD)) u_gap_junction (
		.gap(gj.junction)
	);

	// Step timing and output sample
	step_sequencer u_step_sequencer (
		.clk(clk), .reset(reset),
		.v_n1(v_n1), .v_n2(v_n2), .v_n3(v_n3), .v_n4(v_n4),
		.spikes({spikes_b, spikes_a}),
		.sel_left(sel_left), .sel_right(sel_right), .sample_ready(sample_ready),
		.step(step), .sample_valid(sample_valid),
		.sample_left(sample_left), .sample_right(sample_right),
		.sample_spikes(sample_spikes)
	);

endmodule

// File: verification/neuro_asserts.sv
/*
 * Handshake and step sequencing assertions
 * Bound to the network top level
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module neuro_asserts
(
	input logic               clk,
	input logic               reset,
	input logic               step,
	input logic               sample_valid,
	input logic               sample_ready,
	input neuro_pkg::sample_t sample_left,
	input neuro_pkg::sample_t sample_right,
	input logic [3:0]         sample_spikes
);

	// Held sample stays put until taken
	a_hold: assert property (@(posedge clk) disable iff (reset)
		sample_valid && !sample_ready |=> sample_valid && $stable(sample_left)
			&& $stable(sample_right) && $stable(sample_spikes))
		else $error("Sample dropped or changed before it was accepted");

	// Divider restarts on the accept, next step a full period later
	a_no_step: assert property (@(posedge clk) disable iff (reset)
		sample_valid && sample_ready |=> !step [*`NEURO_STEP_DIV - 1] ##1 step)
		else $error("Step not exactly one divider period after the accept");

	//////////////////////////////////////////////////
	// Step to valid timing
	//////////////////////////////////////////////////
	// Step edge, then the capture edge raises valid
	a_step_valid: assert property (@(posedge clk) disable iff (reset)
		step |-> ##2 sample_valid)
		else $error("No sample_valid on the edge after the step edge");

	a_valid_step: assert property (@(posedge clk) disable iff (reset)
		$rose(sample_valid) |-> $past(step, 2))
		else $error("sample_valid rose without a step on the edge before");

	a_reset: assert property (@(posedge clk)
		reset |=> !sample_valid && !step)
		else $error("sample_valid or step high after reset");

endmodule

bind neuro_top neuro_asserts u_neuro_asserts (
	.clk(clk), .reset(reset), .step(step),
	.sample_valid(sample_valid), .sample_ready(sample_ready),
	.sample_left(sample_left), .sample_right(sample_right),
	.sample_spikes(sample_spikes)
);

// File: verification/neuro_ref_model.svh
/*
 * Reference model of the four-neuron network
 * Integer arithmetic, wrapped back to 18-bit 2.16 after each operation
 */
`ifndef NEURO_REF_MODEL_SVH
`define NEURO_REF_MODEL_SVH

localparam int M_V_RESET  = `NEURO_V_RESET;
localparam int M_U_RESET  = `NEURO_U_RESET;
localparam int M_V_PEAK   = `NEURO_V_PEAK;
localparam int M_C14      = `NEURO_C14;
localparam int M_A_SHIFT  = `NEURO_A_SHIFT;
localparam int M_B_SHIFT  = `NEURO_B_SHIFT;
localparam int M_C_RESET  = `NEURO_C_RESET;
localparam int M_D_JUMP   = `NEURO_D_JUMP;
localparam int M_SYN_W    = `NEURO_SYN_WEIGHT;
localparam int M_SYN_TAU  = `NEURO_SYN_TAU;
localparam int M_I_BASE   = `NEURO_I_BASE;
localparam int M_I_DELTA  = `NEURO_I_DELTA;
localparam int M_GJ_COND  = `NEURO_GJ_COND;

int model_v [4];		// Neurons 1 to 4
int model_u [4];
bit model_spk [4];
int model_syn [4];		// Inhibition onto each neuron

// Keep the low 18 bits, sign-extended
function automatic int wrap18(longint x);
	logic signed [17:0] t;
	t = x[17:0];
	return int'(t);
endfunction

// v squared, sign bit and bits 32 down to 16
function automatic int square_fix(int x);
	logic signed [63:0] p;
	logic signed [17:0] r;
	p = longint'(x) * longint'(x);
	r = {p[35], p[32:16]};
	return int'(r);
endfunction

task automatic neuron_update(input int i_in, inout int v, inout int u, inout bit spk);
	int sum;
	int v_new;
	int u_new;
	if (v > M_V_PEAK)
	begin
		v_new = M_C_RESET;					// Spike, jump back
		u_new = wrap18(u + M_D_JUMP);
		spk   = 1'b1;
	end
	else
	begin
		sum   = wrap18(square_fix(v) + v + (v >>> 2) + (M_C14 >>> 2) - (u >>> 2)
			+ (i_in >>> 2));
		v_new = wrap18(v + (sum >>> 2));
		sum   = wrap18(wrap18((v >>> M_B_SHIFT) - u) >>> M_A_SHIFT);
		u_new = wrap18(u + (sum >>> 4));	// dt of 1/16
		spk   = 1'b0;
	end
	v = v_new;
	u = u_new;
endtask

task automatic model_reset();
	int n;
	for (n = 0; n < 4; n++)
	begin
		model_v[n]   = M_V_RESET;
		model_u[n]   = M_U_RESET;
		model_spk[n] = 1'b0;
		model_syn[n] = 0;
	end
endtask

// One network time step, all currents from the old state
task automatic model_step();
	int n;
	int diff;
	int i_in [4];
	int syn_next [4];
	diff = wrap18(model_v[0] - model_v[2]);
	if (diff < 0)
		diff = 0;							// Forward junction, 1 into 3 only
	i_in[0] = wrap18(wrap18(model_syn[0] + M_I_BASE) + (wrap18(-diff) >>> M_GJ_COND));
	i_in[1] = wrap18(model_syn[1] + M_I_BASE + M_I_DELTA);
	i_in[2] = wrap18(wrap18(model_syn[2] + M_I_BASE - M_I_DELTA) + (diff >>> M_GJ_COND));
	i_in[3] = wrap18(model_syn[3] + M_I_BASE - M_I_DELTA);
	// Partner of neuron n is n ^ 1
	for (n = 0; n < 4; n++)
		syn_next[n] = wrap18(model_syn[n] - (model_syn[n] >>> M_SYN_TAU)
			+ (model_spk[n ^ 1] ? M_SYN_W : 0));
	for (n = 0; n < 4; n++)
		neuron_update(i_in[n], model_v[n], model_u[n], model_spk[n]);
	model_syn = syn_next;
endtask

// Top 16 bits of a voltage
function automatic logic [15:0] model_voltage(int idx);
	logic [31:0] bits;
	bits = model_v[idx];
	return bits[17:2];
endfunction

function automatic logic [3:0] model_spikes();
	return {model_spk[3], model_spk[2], model_spk[1], model_spk[0]};
endfunction

`endif

// File: verification/neuro_tb.sv
/*
 * Testbench for the four-neuron network
 * Random ready and selects from a fixed seed, every accepted sample
 * compared with a step-by-step fixed-point model
 */
`timescale 1ns/10ps
`include "neuro_config.svh"

module neuro_tb;
	import neuro_pkg::*;

	localparam int NUM_SAMPLES = 400;
	localparam int WAIT_LIMIT  = 4 * `NEURO_STEP_DIV;
	localparam int MAX_STALL   = 12;		// Longest back-pressure stretch

	logic       clk;
	logic       reset;
	logic       sel_left;
	logic       sel_right;
	logic       sample_ready;
	logic       sample_valid;
	sample_t    sample_left;
	sample_t    sample_right;
	logic [3:0] sample_spikes;

	int         error_count;
	int         check_count;
	int         sample_count;
	bit         timed_out;
	logic [3:0] spikes_seen;				// One bit per neuron

	`include "neuro_ref_model.svh"

	neuro_top dut (
		.clk(clk), .reset(reset), .sel_left(sel_left), .sel_right(sel_right),
		.sample_ready(sample_ready), .sample_valid(sample_valid),
		.sample_left(sample_left), .sample_right(sample_right),
		.sample_spikes(sample_spikes)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: actual 0x%0h expected 0x%0h at %0t",
				name, actual, expected, $time);
		end
	endtask

	// Selects held steady, ready has no effect while empty
	task automatic wait_valid(output int cycles);
		cycles = 0;
		while (!sample_valid && !timed_out)
		begin
			sample_ready = 1'($urandom);
			@(posedge clk);
			#1;
			cycles++;
			if (!sample_valid && cycles >= WAIT_LIMIT)
			begin
				$display("Timeout, no sample_valid within %0d cycles", WAIT_LIMIT);
				error_count++;
				timed_out = 1'b1;
			end
		end
	endtask

	// Random stall with select toggling, then take the sample
	task automatic accept_sample(input logic [15:0] exp_left, input logic [15:0] exp_right,
		input logic [3:0] exp_spikes);
		int stall;
		int c;
		stall = ($urandom % 3 == 0) ? int'($urandom % MAX_STALL) + 1 : 0;
		for (c = 0; c < stall; c++)
		begin
			sample_ready = 1'b0;
			sel_left     = 1'($urandom);
			sel_right    = 1'($urandom);
			@(posedge clk);
			#1;
			check_value("sample_valid", sample_valid, 1);
			check_value("sample_left", sample_left, exp_left);
			check_value("sample_right", sample_right, exp_right);
			check_value("sample_spikes", sample_spikes, exp_spikes);
		end
		sample_ready = 1'b1;
		sel_left     = 1'($urandom);
		sel_right    = 1'($urandom);
		@(posedge clk);
		#1;
		check_value("sample_valid", sample_valid, 0);	// Dropped on accept
		sample_ready = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int          cycles;
		int          n;
		logic        sel_l_used;
		logic        sel_r_used;
		logic [15:0] exp_left;
		logic [15:0] exp_right;
		logic [3:0]  exp_spikes;

		void'($urandom(89));
		reset        = 1'b1;
		sel_left     = 1'b0;
		sel_right    = 1'b0;
		sample_ready = 1'b0;
		error_count  = 0;
		check_count  = 0;
		sample_count = 0;
		timed_out    = 1'b0;
		spikes_seen  = '0;
		model_reset();

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("sample_valid", sample_valid, 0);

		while (sample_count < NUM_SAMPLES && !timed_out)
		begin
			sel_left   = 1'($urandom);	// Held until the capture edge
			sel_right  = 1'($urandom);
			sel_l_used = sel_left;
			sel_r_used = sel_right;
			wait_valid(cycles);
			if (!timed_out)
			begin
				if (sample_count == 0 && cycles < `NEURO_STEP_DIV + 1)
				begin
					$display("First sample_valid after %0d cycles, before a full step", cycles);
					error_count++;
				end
				model_step();
				exp_left   = sel_l_used ? model_voltage(0) : model_voltage(1);
				exp_right  = sel_r_used ? model_voltage(2) : model_voltage(3);
				exp_spikes = model_spikes();
				check_value("sample_left", sample_left, exp_left);
				check_value("sample_right", sample_right, exp_right);
				check_value("sample_spikes", sample_spikes, exp_spikes);
				spikes_seen |= sample_spikes;
				accept_sample(exp_left, exp_right, exp_spikes);
				sample_count++;
			end
		end

		if (!timed_out)
		begin
			for (n = 0; n < 4; n++)
			begin
				if (!spikes_seen[n])
				begin
					$display("Neuron %0d never spiked in %0d samples", n + 1, sample_count);
					error_count++;
				end
			end
		end

		$display("Samples %0d, checks %0d, errors %0d", sample_count, check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
+incdir+verification
design/neuro_pkg.sv
design/gap_junction_if.sv
design/izh_neuron.sv
design/neuron_pair.sv
design/gap_junction.sv
design/step_sequencer.sv
design/neuro_top.sv
verification/neuro_asserts.sv
verification/neuro_tb.sv
